// File: source/filter_cond_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, compare opcodes and packet layout of the filter engine.
// A packed packet is {data, to, src, seq_done}, data in the top bits.
// All compares are unsigned.
// ----------------------------------------------------------------------
package filter_cond_pkg;

    // Field and word widths
    localparam int data_w      = 32;
    localparam int field_w     = 8;
    localparam int field_count = 4;
    localparam int route_w     = 4;

    // Packed packet as stored in the FIFOs
    localparam int packet_w = data_w + 2 * route_w + 1;

    // Compare opcodes
    localparam int op_w = 2;
    localparam logic [op_w-1:0] op_eq = 2'd0;
    localparam logic [op_w-1:0] op_ne = 2'd1;
    localparam logic [op_w-1:0] op_lt = 2'd2;
    localparam logic [op_w-1:0] op_gt = 2'd3;

    // Data word read as a whole or as byte fields, field 0 in the low byte
    typedef union packed {
        logic [data_w-1:0]                     word;
        logic [field_count-1:0][field_w-1:0]   field;
    } filter_data_u;

    // Builds the FIFO word from the packet fields
    function automatic logic [packet_w-1:0] pack_packet(
        input logic [data_w-1:0]  data,
        input logic [route_w-1:0] to,
        input logic [route_w-1:0] src,
        input logic               seq_done
    );
        return {data, to, src, seq_done};
    endfunction

endpackage

// File: source/packet_fifo.sv
// ----------------------------------------------------------------------
// Synchronous FIFO with first-word fall-through on dout.
// Writes while full and reads while empty are ignored.
// ----------------------------------------------------------------------
module packet_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_generator,
    input  logic                                 wr_en,
    input  logic [filter_cond_pkg::packet_w-1:0] din,
    input  logic                                 rd_en,
    output logic [filter_cond_pkg::packet_w-1:0] dout,
    output logic                                 empty,
    output logic                                 full,
    output logic                                 prog_full
);

    localparam int ptr_w = $clog2(DEPTH);
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [filter_cond_pkg::packet_w-1:0] mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == cnt_w'(DEPTH));
    assign prog_full = (count >= cnt_w'(PROG_THRESH));

endmodule

// File: source/filter_control.sv
// ----------------------------------------------------------------------
// Configuration register and run FSM: idle, active, drain.
// cfg_valid starts a run, a sequence-done read ends it.
// Configuration is relatched on any cfg_valid.
// ----------------------------------------------------------------------
module filter_control (
    input  logic                                  ap_clk,
    input  logic                                  areset_generator,
    input  logic                                  cfg_valid,
    input  logic [filter_cond_pkg::op_w-1:0]      cfg_op,
    input  logic                                  cfg_word_mode,
    input  logic [$clog2(filter_cond_pkg::field_count)-1:0] cfg_field_sel,
    input  logic [filter_cond_pkg::data_w-1:0]    cfg_threshold,
    input  logic                                  cfg_invert,
    input  logic                                  cfg_cond,
    input  logic [filter_cond_pkg::route_w-1:0]   cfg_route_if,
    input  logic [filter_cond_pkg::route_w-1:0]   cfg_route_else,
    input  logic                                  seq_done_read,
    input  logic                                  pipe_busy,
    input  logic                                  fifos_empty,
    output logic                                  run,
    output logic [filter_cond_pkg::op_w-1:0]      op,
    output logic                                  word_mode,
    output logic [$clog2(filter_cond_pkg::field_count)-1:0] field_sel,
    output logic [filter_cond_pkg::data_w-1:0]    threshold,
    output logic                                  invert,
    output logic                                  cond,
    output logic [filter_cond_pkg::route_w-1:0]   route_if,
    output logic [filter_cond_pkg::route_w-1:0]   route_else,
    output logic                                  done_out
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_active = 2'd1;
    localparam logic [1:0] st_drain  = 2'd2;

    logic [1:0] state;

    always_ff @(posedge ap_clk) begin
        if (cfg_valid) begin
            op         <= cfg_op;
            word_mode  <= cfg_word_mode;
            field_sel  <= cfg_field_sel;
            threshold  <= cfg_threshold;
            invert     <= cfg_invert;
            cond       <= cfg_cond;
            route_if   <= cfg_route_if;
            route_else <= cfg_route_else;
        end
    end

    // ------------------------------------------------------------------
    // Run state machine
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state    <= st_idle;
            done_out <= 1'b0;
        end else begin
            case (state)
                st_idle:   if (cfg_valid) state <= st_active;
                st_active: if (seq_done_read) state <= st_drain;
                st_drain:  if (!pipe_busy) state <= st_idle;
                default:   state <= st_idle;
            endcase
            done_out <= (state == st_idle) & fifos_empty;
        end
    end

    assign run = (state == st_active);

endmodule

// File: source/packet_decode.sv
// ----------------------------------------------------------------------
// Stage 1: pops the input FIFO and registers the packet with its
// compare operand. A field operand is zero-extended to the word.
// ----------------------------------------------------------------------
module packet_decode (
    input  logic                                 ap_clk,
    input  logic                                 areset_generator,
    input  logic                                 run,
    input  logic                                 out_fifo_prog_full,
    input  logic                                 fifo_empty,
    input  logic [filter_cond_pkg::packet_w-1:0] fifo_dout,
    input  logic                                 word_mode,
    input  logic [$clog2(filter_cond_pkg::field_count)-1:0] field_sel,
    output logic                                 fifo_rd_en,
    output logic                                 seq_done_read,
    output logic                                 s1_valid,
    output logic [filter_cond_pkg::data_w-1:0]   s1_operand,
    output logic [filter_cond_pkg::data_w-1:0]   s1_data,
    output logic [filter_cond_pkg::route_w-1:0]  s1_to,
    output logic [filter_cond_pkg::route_w-1:0]  s1_src,
    output logic                                 s1_seq_done
);

    filter_cond_pkg::filter_data_u            head_data;
    logic [filter_cond_pkg::route_w-1:0]      head_to;
    logic [filter_cond_pkg::route_w-1:0]      head_src;
    logic                                     head_seq_done;

    assign {head_data, head_to, head_src, head_seq_done} = fifo_dout;

    // Pop only with room for the packets already in flight
    assign fifo_rd_en    = run & ~fifo_empty & ~out_fifo_prog_full;
    assign seq_done_read = fifo_rd_en & head_seq_done;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= fifo_rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_operand  <= word_mode ? head_data.word
                                 : filter_cond_pkg::data_w'(head_data.field[field_sel]);
        s1_data     <= head_data.word;
        s1_to       <= head_to;
        s1_src      <= head_src;
        s1_seq_done <= head_seq_done;
    end

endmodule

// File: source/filter_compare.sv
// ----------------------------------------------------------------------
// Stage 2: unsigned compare of the operand against the threshold.
// Sequence-done packets are always forwarded.
// ----------------------------------------------------------------------
module filter_compare (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                s1_valid,
    input  logic [filter_cond_pkg::data_w-1:0]  s1_operand,
    input  logic [filter_cond_pkg::data_w-1:0]  s1_data,
    input  logic [filter_cond_pkg::route_w-1:0] s1_to,
    input  logic [filter_cond_pkg::route_w-1:0] s1_src,
    input  logic                                s1_seq_done,
    input  logic [filter_cond_pkg::op_w-1:0]    op,
    input  logic [filter_cond_pkg::data_w-1:0]  threshold,
    input  logic                                invert,
    output logic                                s2_valid,
    output logic                                s2_forward,
    output logic                                s2_flag,
    output logic [filter_cond_pkg::data_w-1:0]  s2_data,
    output logic [filter_cond_pkg::route_w-1:0] s2_to,
    output logic [filter_cond_pkg::route_w-1:0] s2_src,
    output logic                                s2_seq_done
);

    logic flag;

    always_comb begin
        case (op)
            filter_cond_pkg::op_eq: flag = (s1_operand == threshold);
            filter_cond_pkg::op_ne: flag = (s1_operand != threshold);
            filter_cond_pkg::op_lt: flag = (s1_operand <  threshold);
            default:                flag = (s1_operand >  threshold);
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        s2_forward  <= s1_seq_done | (flag ^ invert);
        s2_flag     <= flag;
        s2_data     <= s1_data;
        s2_to       <= s1_to;
        s2_src      <= s1_src;
        s2_seq_done <= s1_seq_done;
    end

endmodule

// File: source/route_result.sv
// ----------------------------------------------------------------------
// Stage 3: final destination and output FIFO write.
// Only sequence-done packets are rerouted; dropped packets end here.
// ----------------------------------------------------------------------
module route_result (
    input  logic                                 ap_clk,
    input  logic                                 areset_generator,
    input  logic                                 s1_valid,
    input  logic                                 s2_valid,
    input  logic                                 s2_forward,
    input  logic                                 s2_flag,
    input  logic [filter_cond_pkg::data_w-1:0]   s2_data,
    input  logic [filter_cond_pkg::route_w-1:0]  s2_to,
    input  logic [filter_cond_pkg::route_w-1:0]  s2_src,
    input  logic                                 s2_seq_done,
    input  logic                                 cond,
    input  logic [filter_cond_pkg::route_w-1:0]  route_if,
    input  logic [filter_cond_pkg::route_w-1:0]  route_else,
    output logic                                 fifo_wr_en,
    output logic [filter_cond_pkg::packet_w-1:0] fifo_din,
    output logic                                 pipe_busy
);

    logic [filter_cond_pkg::route_w-1:0] dest;

    always_comb begin
        if (!s2_seq_done) begin
            dest = s2_to;
        end else if (cond) begin
            dest = s2_flag ? route_if : route_else;
        end else begin
            // Back to the sender of the sequence
            dest = s2_src;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= s2_valid & s2_forward;
        end
    end

    always_ff @(posedge ap_clk) begin
        fifo_din <= filter_cond_pkg::pack_packet(s2_data, dest, s2_src, s2_seq_done);
    end

    assign pipe_busy = s1_valid | s2_valid | fifo_wr_en;

endmodule

// File: source/filter_cond_top.sv
// ----------------------------------------------------------------------
// Filter-and-route engine: input FIFO, three-stage pipeline, output FIFO.
// Senders must hold off while in_almost_full is high.
// PROG_THRESH must not exceed FIFO_DEPTH - 3.
// ----------------------------------------------------------------------
module filter_cond_top #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_generator,
    input  logic                                  cfg_valid,
    input  logic [filter_cond_pkg::op_w-1:0]      cfg_op,
    input  logic                                  cfg_word_mode,
    input  logic [$clog2(filter_cond_pkg::field_count)-1:0] cfg_field_sel,
    input  logic [filter_cond_pkg::data_w-1:0]    cfg_threshold,
    input  logic                                  cfg_invert,
    input  logic                                  cfg_cond,
    input  logic [filter_cond_pkg::route_w-1:0]   cfg_route_if,
    input  logic [filter_cond_pkg::route_w-1:0]   cfg_route_else,
    input  logic                                  in_valid,
    input  logic [filter_cond_pkg::data_w-1:0]    in_data,
    input  logic [filter_cond_pkg::route_w-1:0]   in_to,
    input  logic [filter_cond_pkg::route_w-1:0]   in_src,
    input  logic                                  in_seq_done,
    input  logic                                  out_ready,
    output logic                                  in_almost_full,
    output logic                                  out_valid,
    output logic [filter_cond_pkg::data_w-1:0]    out_data,
    output logic [filter_cond_pkg::route_w-1:0]   out_to,
    output logic [filter_cond_pkg::route_w-1:0]   out_src,
    output logic                                  out_seq_done,
    output logic                                  done_out
);

    // Held configuration
    logic [filter_cond_pkg::op_w-1:0]     op;
    logic                                 word_mode;
    logic [$clog2(filter_cond_pkg::field_count)-1:0] field_sel;
    logic [filter_cond_pkg::data_w-1:0]   threshold;
    logic                                 invert;
    logic                                 cond;
    logic [filter_cond_pkg::route_w-1:0]  route_if;
    logic [filter_cond_pkg::route_w-1:0]  route_else;
    logic                                 run;

    // FIFO sides
    logic [filter_cond_pkg::packet_w-1:0] in_fifo_dout;
    logic                                 in_fifo_empty;
    logic                                 in_fifo_rd_en;
    logic [filter_cond_pkg::packet_w-1:0] out_fifo_din;
    logic [filter_cond_pkg::packet_w-1:0] out_fifo_dout;
    logic                                 out_fifo_wr_en;
    logic                                 out_fifo_empty;
    logic                                 out_fifo_full;
    logic                                 out_fifo_prog_full;

    // ------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------
    logic                                 seq_done_read;
    logic                                 pipe_busy;
    logic                                 s1_valid;
    logic [filter_cond_pkg::data_w-1:0]   s1_operand;
    logic [filter_cond_pkg::data_w-1:0]   s1_data;
    logic [filter_cond_pkg::route_w-1:0]  s1_to;
    logic [filter_cond_pkg::route_w-1:0]  s1_src;
    logic                                 s1_seq_done;
    logic                                 s2_valid;
    logic                                 s2_forward;
    logic                                 s2_flag;
    logic [filter_cond_pkg::data_w-1:0]   s2_data;
    logic [filter_cond_pkg::route_w-1:0]  s2_to;
    logic [filter_cond_pkg::route_w-1:0]  s2_src;
    logic                                 s2_seq_done;

    assign out_valid = ~out_fifo_empty;
    assign {out_data, out_to, out_src, out_seq_done} = out_fifo_dout;

    packet_fifo #(.DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) input_fifo_i (
        .ap_clk, .areset_generator,
        .wr_en(in_valid),
        .din(filter_cond_pkg::pack_packet(in_data, in_to, in_src, in_seq_done)),
        .rd_en(in_fifo_rd_en), .dout(in_fifo_dout), .empty(in_fifo_empty),
        .full(), .prog_full(in_almost_full)
    );

    filter_control control_i (
        .ap_clk, .areset_generator,
        .cfg_valid, .cfg_op, .cfg_word_mode, .cfg_field_sel, .cfg_threshold,
        .cfg_invert, .cfg_cond, .cfg_route_if, .cfg_route_else,
        .seq_done_read, .pipe_busy,
        .fifos_empty(in_fifo_empty & out_fifo_empty),
        .run, .op, .word_mode, .field_sel, .threshold, .invert, .cond,
        .route_if, .route_else, .done_out
    );

    packet_decode decode_i (
        .ap_clk, .areset_generator, .run,
        .out_fifo_prog_full, .fifo_empty(in_fifo_empty), .fifo_dout(in_fifo_dout),
        .word_mode, .field_sel, .fifo_rd_en(in_fifo_rd_en), .seq_done_read,
        .s1_valid, .s1_operand, .s1_data, .s1_to, .s1_src, .s1_seq_done
    );

    filter_compare compare_i (
        .ap_clk, .areset_generator,
        .s1_valid, .s1_operand, .s1_data, .s1_to, .s1_src, .s1_seq_done,
        .op, .threshold, .invert,
        .s2_valid, .s2_forward, .s2_flag, .s2_data, .s2_to, .s2_src, .s2_seq_done
    );

    route_result route_i (
        .ap_clk, .areset_generator, .s1_valid,
        .s2_valid, .s2_forward, .s2_flag, .s2_data, .s2_to, .s2_src, .s2_seq_done,
        .cond, .route_if, .route_else,
        .fifo_wr_en(out_fifo_wr_en), .fifo_din(out_fifo_din), .pipe_busy
    );

    packet_fifo #(.DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) output_fifo_i (
        .ap_clk, .areset_generator,
        .wr_en(out_fifo_wr_en), .din(out_fifo_din),
        .rd_en(out_ready), .dout(out_fifo_dout), .empty(out_fifo_empty),
        .full(out_fifo_full), .prog_full(out_fifo_prog_full)
    );

endmodule

// File: test/filter_cond_properties.sv
// ----------------------------------------------------------------------
// Concurrent checks on the engine top level, attached with bind.
// ----------------------------------------------------------------------
module filter_cond_properties (
    input logic ap_clk,
    input logic areset_generator,
    input logic out_fifo_wr_en,
    input logic out_fifo_full,
    input logic done_out,
    input logic out_valid,
    input logic in_almost_full
);
    timeunit 1ns;
    timeprecision 100ps;

    // The three in-flight packets must always fit
    no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(out_fifo_wr_en && out_fifo_full))
        else $error("output FIFO written while full");

    done_means_empty: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done_out |-> !out_valid)
        else $error("done_out high with output data pending");

    clear_after_reset: assert property (@(posedge ap_clk)
        $past(areset_generator) |-> !in_almost_full)
        else $error("in_almost_full high right after reset");

endmodule

bind filter_cond_top filter_cond_properties props_i (
    .ap_clk(ap_clk),
    .areset_generator(areset_generator),
    .out_fifo_wr_en(out_fifo_wr_en),
    .out_fifo_full(out_fifo_full),
    .done_out(done_out),
    .out_valid(out_valid),
    .in_almost_full(in_almost_full)
);

// File: test/filter_cond_tb.sv
// ----------------------------------------------------------------------
// Testbench for the filter engine. Every run ends with one sequence-done
// packet, and the next configuration is sent only once done_out is high.
// ----------------------------------------------------------------------
module filter_cond_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 4000;
    localparam int dw = filter_cond_pkg::data_w;
    localparam int rw = filter_cond_pkg::route_w;

    logic ap_clk;
    logic areset_generator;
    logic cfg_valid, cfg_word_mode, cfg_invert, cfg_cond;
    logic [filter_cond_pkg::op_w-1:0] cfg_op;
    logic [1:0] cfg_field_sel;
    logic [dw-1:0] cfg_threshold, in_data, out_data;
    logic [rw-1:0] cfg_route_if, cfg_route_else, in_to, in_src, out_to, out_src;
    logic in_valid, in_seq_done, out_ready;
    logic in_almost_full, out_valid, out_seq_done, done_out;

    // Configuration seen by the reference model
    logic [filter_cond_pkg::op_w-1:0] cur_op;
    logic cur_word_mode, cur_invert, cur_cond;
    logic [1:0] cur_field_sel;
    logic [dw-1:0] cur_threshold;
    logic [rw-1:0] cur_route_if, cur_route_else;

    // Predicted output packets, in order
    logic [dw-1:0] exp_data_q[$];
    logic [rw-1:0] exp_to_q[$];
    logic [rw-1:0] exp_src_q[$];
    logic exp_seq_q[$];

    integer seed;
    int mismatch_count;
    int other_count;
    int cycle_count;
    filter_cond_pkg::filter_data_u got_word;
    filter_cond_pkg::filter_data_u exp_word;

    filter_cond_top dut_i (.*);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------------
    function automatic logic predict_packet(input logic [dw-1:0] data,
                                            input logic [rw-1:0] to,
                                            input logic [rw-1:0] src,
                                            input logic seq_done,
                                            output logic [rw-1:0] dest);
        filter_cond_pkg::filter_data_u d;
        logic [dw-1:0] operand;
        logic flag;
        d.word = data;
        if (cur_word_mode) begin
            operand = d.word;
        end else begin
            operand = {{(dw - filter_cond_pkg::field_w){1'b0}}, d.field[cur_field_sel]};
        end
        case (cur_op)
            filter_cond_pkg::op_eq: flag = (operand == cur_threshold);
            filter_cond_pkg::op_ne: flag = (operand != cur_threshold);
            filter_cond_pkg::op_lt: flag = (operand < cur_threshold);
            default:                flag = (operand > cur_threshold);
        endcase
        if (!seq_done) begin
            dest = to;
        end else begin
            dest = cur_cond ? (flag ? cur_route_if : cur_route_else) : src;
        end
        return seq_done | (flag ^ cur_invert);
    endfunction

    task automatic check_data(input string name, input filter_cond_pkg::filter_data_u got,
                              input filter_cond_pkg::filter_data_u exp);
        if (got.word !== exp.word) begin
            $display("Mismatch %s: got %h expected %h", name, got.word, exp.word);
            mismatch_count++;
        end
    endtask

    task automatic check_route(input string name, input logic [rw-1:0] got,
                               input logic [rw-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    // Output handshake sampled mid-cycle, where everything is settled
    always @(negedge ap_clk) begin
        if (!areset_generator && out_valid && out_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("Output packet arrived but no packet was expected");
                other_count++;
            end else begin
                got_word.word = out_data;
                exp_word.word = exp_data_q.pop_front();
                check_data("out_data", got_word, exp_word);
                check_route("out_to", out_to, exp_to_q.pop_front());
                check_route("out_src", out_src, exp_src_q.pop_front());
                check_flag("out_seq_done", out_seq_done, exp_seq_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus, each task starts and ends just after a rising edge
    // ------------------------------------------------------------------
    task automatic configure(input logic [1:0] op, input logic word_mode,
                             input logic [1:0] field_sel, input logic [dw-1:0] threshold,
                             input logic invert, input logic cond,
                             input logic [rw-1:0] route_if, input logic [rw-1:0] route_else);
        cur_op = op;
        cur_word_mode = word_mode;
        cur_field_sel = field_sel;
        cur_threshold = threshold;
        cur_invert = invert;
        cur_cond = cond;
        cur_route_if = route_if;
        cur_route_else = route_else;
        cfg_op = op;
        cfg_word_mode = word_mode;
        cfg_field_sel = field_sel;
        cfg_threshold = threshold;
        cfg_invert = invert;
        cfg_cond = cond;
        cfg_route_if = route_if;
        cfg_route_else = route_else;
        cfg_valid = 1'b1;
        @(posedge ap_clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic push_packet(input logic [dw-1:0] data, input logic [rw-1:0] to,
                               input logic [rw-1:0] src, input logic seq_done);
        logic [rw-1:0] dest;
        while (in_almost_full) begin
            @(posedge ap_clk);
            #2;
        end
        in_valid = 1'b1;
        in_data = data;
        in_to = to;
        in_src = src;
        in_seq_done = seq_done;
        if (predict_packet(data, to, src, seq_done, dest)) begin
            exp_data_q.push_back(data);
            exp_to_q.push_back(dest);
            exp_src_q.push_back(src);
            exp_seq_q.push_back(seq_done);
        end
        @(posedge ap_clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Output drained first, then done_out gets a short window to rise
    task automatic wait_done();
        int idle_wait;
        while (out_valid || exp_data_q.size() != 0) begin
            @(posedge ap_clk);
            #2;
        end
        idle_wait = 0;
        while (!done_out && idle_wait < 8) begin
            @(posedge ap_clk);
            #2;
            idle_wait++;
        end
        check_flag("done_out", done_out, 1'b1);
    endtask

    initial begin
        filter_cond_pkg::filter_data_u d;
        logic [7:0] thr;
        logic saw_full;
        int n;
        seed = 32'he5f5_9925;
        mismatch_count = 0;
        other_count = 0;
        cycle_count = 0;
        areset_generator = 1'b1;
        cfg_valid = 1'b0;
        cfg_op = '0;
        cfg_word_mode = 1'b0;
        cfg_field_sel = '0;
        cfg_threshold = '0;
        cfg_invert = 1'b0;
        cfg_cond = 1'b0;
        cfg_route_if = '0;
        cfg_route_else = '0;
        in_valid = 1'b0;
        in_data = '0;
        in_to = '0;
        in_src = '0;
        in_seq_done = 1'b0;
        out_ready = 1'b1;
        repeat (8) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;

        // Reset state
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_almost_full", in_almost_full, 1'b0);
        wait_done();

        // Field mode over every opcode and field
        for (int op = 0; op < 4; op++) begin
            for (int f = 0; f < 4; f++) begin
                thr = 8'($random(seed));
                configure(2'(op), 1'b0, 2'(f), {24'd0, thr}, 1'b0, 1'b0, 4'h1, 4'h2);
                for (int i = 0; i < 12; i++) begin
                    d.word = $random(seed);
                    if (($random(seed) & 3) == 0) begin
                        d.field[f] = thr;
                    end
                    push_packet(d.word, 4'($random(seed)), 4'($random(seed)), 1'b0);
                end
                push_packet($random(seed), 4'($random(seed)), 4'($random(seed)), 1'b1);
                wait_done();
            end
        end

        // Word mode, inverted decision
        configure(filter_cond_pkg::op_lt, 1'b1, 2'd0, 32'h8000_0000, 1'b1, 1'b0, 4'h3, 4'h4);
        for (int i = 0; i < 20; i++) begin
            push_packet($random(seed), 4'($random(seed)), 4'($random(seed)), 1'b0);
        end
        push_packet(32'h0000_0010, 4'h6, 4'h7, 1'b1);
        wait_done();

        // Sequence-done routing: back to source, then by the flag
        configure(filter_cond_pkg::op_eq, 1'b1, 2'd0, 32'h1234_5678, 1'b0, 1'b0, 4'ha, 4'hb);
        push_packet(32'h1234_5678, 4'h9, 4'h5, 1'b1);
        wait_done();
        configure(filter_cond_pkg::op_eq, 1'b1, 2'd0, 32'h1234_5678, 1'b0, 1'b1, 4'ha, 4'hb);
        push_packet(32'h1234_5678, 4'h9, 4'h5, 1'b1);
        wait_done();
        configure(filter_cond_pkg::op_eq, 1'b1, 2'd0, 32'h1234_5678, 1'b0, 1'b1, 4'hc, 4'hd);
        push_packet(32'h0bad_0bad, 4'h9, 4'h5, 1'b1);
        wait_done();

        // Back-pressure until the input side reports almost full
        configure(filter_cond_pkg::op_ne, 1'b1, 2'd0, 32'hffff_ffff, 1'b0, 1'b0, 4'h0, 4'h0);
        out_ready = 1'b0;
        n = 0;
        while (!in_almost_full && n < 40) begin
            push_packet($random(seed), 4'($random(seed)), 4'($random(seed)), 1'b0);
            n++;
        end
        saw_full = in_almost_full;
        check_flag("in_almost_full", saw_full, 1'b1);
        repeat (10) @(posedge ap_clk);
        #2;
        out_ready = 1'b1;
        push_packet($random(seed), 4'h2, 4'h3, 1'b1);
        wait_done();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
source/filter_cond_pkg.sv
source/packet_fifo.sv
source/filter_control.sv
source/packet_decode.sv
source/filter_compare.sv
source/route_result.sv
source/filter_cond_top.sv
test/filter_cond_properties.sv
test/filter_cond_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP      = filter_cond_tb
FILELIST = project.f
LOG      = sim.log
FAIL_MSG = CHECKS FAILED
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
